// File: hdl/addr_translate.sv
`timescale 1ns/10ps
`default_nettype none
`include "cart_defs.svh"

module addr_translate (
  input wire                      CLK,
  input wire                      rst,
  map_req_if.exe                  req,
  output logic [`CART_ADDR_W-1:0] rom_addr
);

  logic                    is_patch;
  logic                    is_sram;
  logic [`CART_ADDR_W-1:0] hi_sram;   // 8 KB save RAM page per bank
  logic [`CART_ADDR_W-1:0] lo_sram;   // 32 KB save RAM page per bank
  logic [`CART_ADDR_W-1:0] flat_rom;
  logic [`CART_ADDR_W-1:0] lo_rom;
  logic [`CART_ADDR_W-1:0] ex_rom;
  logic [`CART_ADDR_W-1:0] addr_nxt;

  assign is_patch = (req.region == cart_pkg::REG_PATCH);
  assign is_sram  = (req.region == cart_pkg::REG_SAVERAM);

  //////////////////////////////
  // Bank folding

  assign hi_sram  = {6'b0, req.addr[20:16], req.addr[12:0]};
  assign lo_sram  = {4'b0, req.addr[20:16], req.addr[14:0]};
  assign flat_rom = {1'b0, req.addr[22:0]};  // A23 mirrors

  // A15 dropped, upper banks first
  assign lo_rom = {1'b0, ~req.addr[23], req.addr[22:16], req.addr[14:0]};

  // C0-FF holds the first 4 MB, 40-7D the rest
  assign ex_rom = {1'b0, ~req.addr[23], req.addr[21:0]};

  //////////////////////////////
  // Per-mapper selection

  always_comb begin
    if (is_patch) begin
      addr_nxt = req.addr;  // Patch region is raw SRAM
    end else begin
      case (req.mapper)
        cart_pkg::MAP_HIROM:
          addr_nxt = is_sram ? (`SAVERAM_BASE + (hi_sram & req.saveram_mask))
                             : (flat_rom & req.rom_mask);
        cart_pkg::MAP_LOROM:
          addr_nxt = is_sram ? (`SAVERAM_BASE + (lo_sram & req.saveram_mask))
                             : (lo_rom & req.rom_mask);
        cart_pkg::MAP_EXHIROM:
          addr_nxt = is_sram ? (`SAVERAM_BASE + (hi_sram & req.saveram_mask))
                             : (ex_rom & req.rom_mask);
        cart_pkg::MAP_MENU:
          // Save RAM banks already point at SRAM directly
          addr_nxt = is_sram ? req.addr
                             : ((flat_rom & req.rom_mask) + `MENU_ROM_BASE);
        default:
          addr_nxt = '0;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      rom_addr <= '0;
    end else begin
      rom_addr <= addr_nxt;
    end
  end

endmodule

`default_nettype wire

// File: hdl/cart_addr_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "cart_defs.svh"

module cart_addr_top (
  input wire                    CLK,
  input wire                    rst,
  input wire [`CART_FEAT_W-1:0] featurebits,
  input wire cart_pkg::mapper_t mapper,
  input wire [`CART_ADDR_W-1:0] snes_addr,
  input wire [`CART_PA_W-1:0]   snes_pa,
  input wire                    snes_romsel,
  input wire [`CART_ADDR_W-1:0] saveram_mask,
  input wire [`CART_ADDR_W-1:0] rom_mask,
  input wire                    map_unlock,
  output wire [`CART_ADDR_W-1:0] rom_addr,
  output wire                    is_rom,
  output wire                    is_saveram,
  output wire                    is_writable,
  output wire                    rom_hit,
  output wire                    msu_enable,
  output wire                    dma_enable,
  output wire                    dspx_enable,
  output wire                    dspx_a0,
  output wire                    r213f_enable,
  output wire                    r2100_hit,
  output wire                    snescmd_enable,
  output wire cart_pkg::cmd_vec_t cmd_vec
);

  map_req_if req_bus ();

  // Stage 1
  map_decode u_decode (
    .CLK          (CLK),
    .rst          (rst),
    .featurebits  (featurebits),
    .mapper       (mapper),
    .snes_addr    (snes_addr),
    .snes_pa      (snes_pa),
    .snes_romsel  (snes_romsel),
    .saveram_mask (saveram_mask),
    .rom_mask     (rom_mask),
    .map_unlock   (map_unlock),
    .req          (req_bus.dec)
  );

  // Stage 2, address and selects side by side
  addr_translate u_translate (
    .CLK      (CLK),
    .rst      (rst),
    .req      (req_bus.exe),
    .rom_addr (rom_addr)
  );

  periph_select u_select (
    .CLK            (CLK),
    .rst            (rst),
    .req            (req_bus.res),
    .is_rom         (is_rom),
    .is_saveram     (is_saveram),
    .is_writable    (is_writable),
    .rom_hit        (rom_hit),
    .msu_enable     (msu_enable),
    .dma_enable     (dma_enable),
    .dspx_enable    (dspx_enable),
    .dspx_a0        (dspx_a0),
    .r213f_enable   (r213f_enable),
    .r2100_hit      (r2100_hit),
    .snescmd_enable (snescmd_enable),
    .cmd_vec        (cmd_vec)
  );

endmodule

`default_nettype wire

// File: hdl/cart_defs.svh
`ifndef CART_DEFS_SVH
`define CART_DEFS_SVH

//////////////////////////////
// Bus widths

`define CART_ADDR_W 24  // A-bus and SRAM address
`define CART_PA_W   8   // B-bus peripheral address
`define CART_FEAT_W 16

//////////////////////////////
// Feature bit positions

// Bit numbers follow the firmware's featurebits word
`define FEAT_DSPX 0
`define FEAT_MSU1 3
`define FEAT_213F 4
`define FEAT_DMA1 11

//////////////////////////////
// SRAM layout

// Save RAM sits at the top 2 MB of SRAM
`define SAVERAM_BASE  24'hE00000
`define MENU_ROM_BASE 24'hC00000  // Menu ROM image below save RAM

`endif

// File: hdl/cart_pkg.sv
`default_nettype none

package cart_pkg;

  // Mapper code as detected by the MCU
  typedef enum logic [2:0] {
    MAP_HIROM   = 3'b000,
    MAP_LOROM   = 3'b001,
    MAP_EXHIROM = 3'b010,
    MAP_MENU    = 3'b111  // Menu ROM in upper SRAM
  } mapper_t;

  // Listed in rising priority
  typedef enum logic [1:0] {
    REG_NONE    = 2'd0,
    REG_ROM     = 2'd1,
    REG_SAVERAM = 2'd2,
    REG_PATCH   = 2'd3
  } region_t;

  // Fixed command vectors in the snescmd area
  typedef enum logic [2:0] {
    CMD_NONE    = 3'd0,
    CMD_NMI     = 3'd1,  // 002BF2
    CMD_RETURN  = 3'd2,  // 002A6C
    CMD_BRANCH1 = 3'd3,  // 002A1F
    CMD_BRANCH2 = 3'd4,  // 002A59
    CMD_BRANCH3 = 3'd5   // 002A5E
  } cmd_vec_t;

endpackage

`default_nettype wire

// File: hdl/map_decode.sv
`timescale 1ns/10ps
`default_nettype none
`include "cart_defs.svh"

module map_decode (
  input wire                    CLK,
  input wire                    rst,
  input wire [`CART_FEAT_W-1:0] featurebits,
  input wire cart_pkg::mapper_t mapper,
  input wire [`CART_ADDR_W-1:0] snes_addr,
  input wire [`CART_PA_W-1:0]   snes_pa,
  input wire                    snes_romsel,
  input wire [`CART_ADDR_W-1:0] saveram_mask,
  input wire [`CART_ADDR_W-1:0] rom_mask,
  input wire                    map_unlock,
  map_req_if.dec                req
);

  logic              in_f0_ff;  // Banks F0-FF
  logic              sram_win;
  logic              is_patch;
  logic              is_sram;
  cart_pkg::region_t region_nxt;

  //////////////////////////////
  // Region classification

  assign in_f0_ff = &snes_addr[23:20];

  // Save RAM window of the current mapper
  always_comb begin
    case (mapper)
      cart_pkg::MAP_HIROM,
      cart_pkg::MAP_EXHIROM:
        // Banks 20-3F/A0-BF, offset 6000-7FFF
        sram_win = ~snes_addr[22] & snes_addr[21] & ~snes_addr[15]
                   & (&snes_addr[14:13]);
      cart_pkg::MAP_LOROM:
        // Banks 70-7F/F0-FF, upper half only left to ROM when ROM is large
        sram_win = (&snes_addr[22:20]) & ~snes_romsel
                   & (~snes_addr[15] | ~rom_mask[21]);
      cart_pkg::MAP_MENU:
        sram_win = in_f0_ff;  // Whole banks
      default:
        sram_win = 1'b0;
    endcase
  end

  assign is_patch = map_unlock & in_f0_ff;
  assign is_sram  = ~map_unlock & saveram_mask[0] & sram_win;

  always_comb begin
    if (is_patch) begin
      region_nxt = cart_pkg::REG_PATCH;
    end else if (is_sram) begin
      region_nxt = cart_pkg::REG_SAVERAM;
    end else if (~snes_romsel) begin
      region_nxt = cart_pkg::REG_ROM;
    end else begin
      region_nxt = cart_pkg::REG_NONE;
    end
  end

  //////////////////////////////
  // Request register

  // Reset leaves an idle bus: ROMSEL high, no B-bus register selected
  always_ff @(posedge CLK) begin
    if (rst) begin
      req.addr         <= '0;
      req.pa           <= '1;
      req.romsel       <= 1'b1;
      req.mapper       <= cart_pkg::MAP_HIROM;
      req.featurebits  <= '0;
      req.saveram_mask <= '0;
      req.rom_mask     <= '0;
      req.map_unlock   <= 1'b0;
      req.region       <= cart_pkg::REG_NONE;
    end else begin
      req.addr         <= snes_addr;
      req.pa           <= snes_pa;
      req.romsel       <= snes_romsel;
      req.mapper       <= mapper;
      req.featurebits  <= featurebits;
      req.saveram_mask <= saveram_mask;
      req.rom_mask     <= rom_mask;
      req.map_unlock   <= map_unlock;
      req.region       <= region_nxt;
    end
  end

endmodule

`default_nettype wire

// File: hdl/map_req_if.sv
`timescale 1ns/10ps
`default_nettype none
`include "cart_defs.svh"

// Registered and classified bus request, one per cycle
interface map_req_if;

  logic [`CART_ADDR_W-1:0] addr;
  logic [`CART_PA_W-1:0]   pa;
  logic                    romsel;  // Active low
  cart_pkg::mapper_t       mapper;
  logic [`CART_FEAT_W-1:0] featurebits;
  logic [`CART_ADDR_W-1:0] saveram_mask;
  logic [`CART_ADDR_W-1:0] rom_mask;
  logic                    map_unlock;
  cart_pkg::region_t       region;

  modport dec (
    output addr, pa, romsel, mapper, featurebits,
    output saveram_mask, rom_mask, map_unlock, region
  );

  // Address translation
  modport exe (input addr, mapper, saveram_mask, rom_mask, region);

  modport res (
    input addr, pa, romsel, mapper, featurebits, rom_mask, map_unlock, region
  );

endinterface

`default_nettype wire

// File: hdl/periph_select.sv
`timescale 1ns/10ps
`default_nettype none
`include "cart_defs.svh"

module periph_select (
  input wire                 CLK,
  input wire                 rst,
  map_req_if.res             req,
  output logic               is_rom,
  output logic               is_saveram,
  output logic               is_writable,
  output logic               rom_hit,
  output logic               msu_enable,
  output logic               dma_enable,
  output logic               dspx_enable,
  output logic               dspx_a0,
  output logic               r213f_enable,
  output logic               r2100_hit,
  output logic               snescmd_enable,
  output cart_pkg::cmd_vec_t cmd_vec
);

  logic               sys_bank;  // A22 clear, I/O visible
  logic               lorom;
  logic               hirom;
  logic               dsp_win;
  logic               dsp_a0_nxt;
  logic               sav_nxt;
  logic               wr_nxt;
  cart_pkg::cmd_vec_t cmd_nxt;

  assign sys_bank = ~req.addr[22];
  assign lorom    = (req.mapper == cart_pkg::MAP_LOROM);
  assign hirom    = (req.mapper == cart_pkg::MAP_HIROM);

  //////////////////////////////
  // DSP coprocessor

  always_comb begin
    if (lorom) begin
      // Large ROM moves the DSP from 30-3F:8000 to 60-6F:0000
      dsp_win = req.rom_mask[20]
                ? (req.addr[22] & req.addr[21] & ~req.addr[20] & ~req.addr[15])
                : (~req.addr[22] & req.addr[21] & req.addr[20] & req.addr[15]);
      dsp_a0_nxt = req.addr[14];
    end else if (hirom) begin
      dsp_win = ~req.addr[22] & ~req.addr[21] & ~req.addr[20] & ~req.addr[15]
                & (&req.addr[14:13]);  // 00-0F:6000-7FFF
      dsp_a0_nxt = req.addr[12];
    end else begin
      dsp_win    = 1'b0;
      dsp_a0_nxt = 1'b1;
    end
  end

  //////////////////////////////
  // Command vectors

  always_comb begin
    case (req.addr)
      24'h002BF2: cmd_nxt = cart_pkg::CMD_NMI;
      24'h002A6C: cmd_nxt = cart_pkg::CMD_RETURN;
      24'h002A1F: cmd_nxt = cart_pkg::CMD_BRANCH1;
      24'h002A59: cmd_nxt = cart_pkg::CMD_BRANCH2;
      24'h002A5E: cmd_nxt = cart_pkg::CMD_BRANCH3;
      default:    cmd_nxt = cart_pkg::CMD_NONE;
    endcase
  end

  assign sav_nxt = (req.region == cart_pkg::REG_SAVERAM);
  assign wr_nxt  = sav_nxt | (req.region == cart_pkg::REG_PATCH);

  always_ff @(posedge CLK) begin
    if (rst) begin
      is_rom         <= 1'b0;
      is_saveram     <= 1'b0;
      is_writable    <= 1'b0;
      rom_hit        <= 1'b0;
      msu_enable     <= 1'b0;
      dma_enable     <= 1'b0;
      dspx_enable    <= 1'b0;
      dspx_a0        <= 1'b0;
      r213f_enable   <= 1'b0;
      r2100_hit      <= 1'b0;
      snescmd_enable <= 1'b0;
      cmd_vec        <= cart_pkg::CMD_NONE;
    end else begin
      is_rom      <= ~req.romsel;  // ROMSEL alone, also under save RAM
      is_saveram  <= sav_nxt;
      is_writable <= wr_nxt;
      rom_hit     <= ~req.romsel | wr_nxt;
      msu_enable  <= req.featurebits[`FEAT_MSU1] & sys_bank
                     & ((req.addr[15:0] & 16'hfff8) == 16'h2000);
      dma_enable  <= (req.featurebits[`FEAT_DMA1] | req.map_unlock) & sys_bank
                     & ((req.addr[15:0] & 16'hfff0) == 16'h2020);
      dspx_enable <= req.featurebits[`FEAT_DSPX] & dsp_win;
      // A0 stays low when no DSP is fitted
      dspx_a0      <= req.featurebits[`FEAT_DSPX] & dsp_a0_nxt;
      r213f_enable <= req.featurebits[`FEAT_213F] & (req.pa == 8'h3f);
      r2100_hit    <= (req.pa == 8'h00);
      // 2A00-2FFF, the 2800-29FF gap left to other devices
      snescmd_enable <= ({req.addr[22], req.addr[15:11]} == 6'b0_00101)
                        & (req.addr[10:9] != 2'b00);
      cmd_vec <= cmd_nxt;
    end
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+hdl
hdl/cart_pkg.sv
hdl/map_req_if.sv
hdl/map_decode.sv
hdl/addr_translate.sv
hdl/periph_select.sv
hdl/cart_addr_top.sv
verification/cart_addr_assertions.sv
verification/cart_addr_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the cart address decoder testbench with Verilator
LOG=sim.log
rm -rf obj_dir "$LOG"
verilator --binary --timing --assert --timescale 1ns/10ps -f list.f \
  --top-module cart_addr_tb -o cart_addr_sim > "$LOG" 2>&1 &&
  ./obj_dir/cart_addr_sim >> "$LOG" 2>&1 ||
  echo "Test FAILED" >> "$LOG"
cat "$LOG"
grep -q "Test FAILED" "$LOG" && exit 1 || exit 0

// File: verification/cart_addr_assertions.sv
`timescale 1ns/10ps
`default_nettype none
`include "cart_defs.svh"

module cart_addr_assertions (
  input wire                     CLK,
  input wire                     rst,
  input wire [`CART_ADDR_W-1:0]  rom_addr,
  input wire                     is_rom,
  input wire                     is_saveram,
  input wire                     is_writable,
  input wire                     rom_hit,
  input wire                     msu_enable,
  input wire                     dma_enable,
  input wire                     dspx_enable,
  input wire                     dspx_a0,
  input wire                     r213f_enable,
  input wire                     r2100_hit,
  input wire                     snescmd_enable,
  input wire cart_pkg::cmd_vec_t cmd_vec
);

  // One edge with rst high clears both stages
  quiet_after_rst: assert property (@(posedge CLK) $past(rst) |->
      (rom_addr == '0) && !is_rom && !is_saveram && !is_writable && !rom_hit
      && !msu_enable && !dma_enable && !dspx_enable && !dspx_a0 && !r213f_enable
      && !r2100_hit && !snescmd_enable && (cmd_vec == cart_pkg::CMD_NONE))
    else $error("outputs not quiet one cycle after reset");

  hit_covers_regions: assert property (@(posedge CLK) disable iff (rst)
      (is_saveram || is_rom) |-> rom_hit)
    else $error("rom_hit low while is_rom or is_saveram is set");

  saveram_writable: assert property (@(posedge CLK) disable iff (rst)
      is_saveram |-> is_writable)
    else $error("save RAM access not marked writable");

endmodule

bind cart_addr_top cart_addr_assertions asrt0 (
  .CLK            (CLK),
  .rst            (rst),
  .rom_addr       (rom_addr),
  .is_rom         (is_rom),
  .is_saveram     (is_saveram),
  .is_writable    (is_writable),
  .rom_hit        (rom_hit),
  .msu_enable     (msu_enable),
  .dma_enable     (dma_enable),
  .dspx_enable    (dspx_enable),
  .dspx_a0        (dspx_a0),
  .r213f_enable   (r213f_enable),
  .r2100_hit      (r2100_hit),
  .snescmd_enable (snescmd_enable),
  .cmd_vec        (cmd_vec)
);

`default_nettype wire

// File: verification/cart_addr_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "cart_defs.svh"

module cart_addr_tb;

  localparam int N_REQ = 4000;

  typedef struct packed {
    logic                    live;  // Set for random requests only
    logic                    rst;
    logic [`CART_FEAT_W-1:0] feat;
    cart_pkg::mapper_t       mapper;
    logic [`CART_ADDR_W-1:0] addr;
    logic [`CART_PA_W-1:0]   pa;
    logic                    romsel;
    logic [`CART_ADDR_W-1:0] sram_mask;
    logic [`CART_ADDR_W-1:0] rom_mask;
    logic                    unlock;
  } stim_t;

  typedef struct packed {
    logic [`CART_ADDR_W-1:0] rom_addr;
    logic                    is_rom;
    logic                    is_saveram;
    logic                    is_writable;
    logic                    rom_hit;
    logic                    msu;
    logic                    dma;
    logic                    dspx;
    logic                    dspx_a0;
    logic                    r213f;
    logic                    r2100;
    logic                    snescmd;
    cart_pkg::cmd_vec_t      cmd;
  } resp_t;

  logic                    CLK = 1'b0;
  logic                    rst;
  logic [`CART_FEAT_W-1:0] featurebits;
  cart_pkg::mapper_t       mapper;
  logic [`CART_ADDR_W-1:0] snes_addr;
  logic [`CART_PA_W-1:0]   snes_pa;
  logic                    snes_romsel;
  logic [`CART_ADDR_W-1:0] saveram_mask;
  logic [`CART_ADDR_W-1:0] rom_mask;
  logic                    map_unlock;
  logic [`CART_ADDR_W-1:0] rom_addr;
  logic                    is_rom;
  logic                    is_saveram;
  logic                    is_writable;
  logic                    rom_hit;
  logic                    msu_enable;
  logic                    dma_enable;
  logic                    dspx_enable;
  logic                    dspx_a0;
  logic                    r213f_enable;
  logic                    r2100_hit;
  logic                    snescmd_enable;
  cart_pkg::cmd_vec_t      cmd_vec;

  int    seed;
  int    addr_errs;
  int    flag_errs;
  int    cmd_errs;
  int    rst_left;   // Edges still driven with rst high
  int    n_sent;
  int    n_checked;
  stim_t hist [0:2];  // [2] is the request now at the outputs
  resp_t exp_r;

  cart_addr_top dut0 (.*);

  initial begin
    forever #2 CLK = ~CLK;
  end

  //////////////////////////////
  // Stimulus

  function automatic stim_t idle_stim(input logic rst_val);
    stim_t s;
    s = '0;
    s.rst = rst_val;
    s.pa = '1;
    s.romsel = 1'b1;
    s.mapper = cart_pkg::MAP_HIROM;
    return s;
  endfunction

  function automatic stim_t rand_stim();
    stim_t       s;
    logic [31:0] r;
    logic [31:0] c;
    logic [31:0] m;
    logic [15:0] off;
    r = $random(seed);
    c = $random(seed);
    s = '0;
    s.live = 1'b1;
    s.feat = c[31:16];
    case (c[2:0])
      3'd0, 3'd1: s.mapper = cart_pkg::MAP_HIROM;
      3'd2, 3'd3: s.mapper = cart_pkg::MAP_LOROM;
      3'd4:       s.mapper = cart_pkg::MAP_EXHIROM;
      3'd5:       s.mapper = cart_pkg::MAP_MENU;
      default:    s.mapper = cart_pkg::mapper_t'({1'b0, c[4:3]} + 3'd3);  // Codes 3-6
    endcase
    case (r[10:8])
      3'd2:    off = {3'b011, r[28:16]};              // Save RAM and DSP pages
      3'd3:    off = {12'h200, r[19:16]};             // MSU and its neighbours
      3'd4:    off = {11'b00100000001, r[20:16]};     // 2020-203F
      3'd5:    off = {5'b00101, r[26:16]};            // snescmd and the gap below
      default: off = r[31:16];
    endcase
    s.addr = {r[7:0], off};
    if (r[10:8] == 3'd6) begin
      case (r[18:16])
        3'd0:    s.addr = 24'h002BF2;
        3'd1:    s.addr = 24'h002A6C;
        3'd2:    s.addr = 24'h002A1F;
        3'd3:    s.addr = 24'h002A59;
        3'd4:    s.addr = 24'h002A5E;
        default: s.addr = 24'h002BF3;  // One past NMI
      endcase
    end
    s.romsel = c[5];
    case (c[7:6])
      2'd0:    s.pa = 8'h3f;
      2'd1:    s.pa = 8'h00;
      default: s.pa = c[15:8];
    endcase
    m = $random(seed);
    s.sram_mask = m[23:0];
    m = $random(seed);
    s.rom_mask = m[23:0];
    s.unlock = (r[12:11] == 2'b00);
    return s;
  endfunction

  task automatic drive_inputs(input stim_t s);
    rst          <= s.rst;
    featurebits  <= s.feat;
    mapper       <= s.mapper;
    snes_addr    <= s.addr;
    snes_pa      <= s.pa;
    snes_romsel  <= s.romsel;
    saveram_mask <= s.sram_mask;
    rom_mask     <= s.rom_mask;
    map_unlock   <= s.unlock;
  endtask

  always @(posedge CLK) begin : drive_proc
    stim_t s;
    if (rst_left > 0) begin
      s = idle_stim(1'b1);
      rst_left--;
    end else if (n_sent < N_REQ) begin
      s = rand_stim();
      n_sent++;
    end else begin
      s = idle_stim(1'b0);  // Drain with a quiet bus
    end
    drive_inputs(s);
    hist[2] = hist[1];
    hist[1] = hist[0];
    hist[0] = s;
  end

  //////////////////////////////
  // Reference model

  function automatic resp_t expect_resp(input stim_t s);
    resp_t                   r;
    logic [15:0]             off;
    logic [6:0]              bank;  // A23 folded away
    logic                    patch;
    logic                    win;
    logic                    sram;
    logic                    dsp;
    logic                    a0;
    logic [`CART_ADDR_W-1:0] rom;
    logic [`CART_ADDR_W-1:0] sav;
    r = '0;
    if (s.rst) return r;
    off = s.addr[15:0];
    bank = s.addr[22:16];
    patch = s.unlock && (s.addr[23:20] == 4'hf);
    win = 1'b0;
    rom = '0;
    sav = '0;
    case (s.mapper)
      cart_pkg::MAP_HIROM, cart_pkg::MAP_EXHIROM: begin
        win = (bank[6:5] == 2'b01) && (off >= 16'h6000) && (off < 16'h8000);
        sav = {6'd0, s.addr[20:16], s.addr[12:0]};
        if (s.mapper == cart_pkg::MAP_HIROM) begin
          rom = {1'b0, s.addr[22:0]};
        end else begin
          rom = {1'b0, ~s.addr[23], s.addr[21:0]};
        end
      end
      cart_pkg::MAP_LOROM: begin
        win = (bank >= 7'h70) && !s.romsel && ((off < 16'h8000) || !s.rom_mask[21]);
        sav = {4'd0, s.addr[20:16], s.addr[14:0]};
        rom = {1'b0, ~s.addr[23], s.addr[22:16], s.addr[14:0]};
      end
      cart_pkg::MAP_MENU: win = (s.addr[23:20] == 4'hf);
      default: win = 1'b0;  // Unmapped codes leave rom at 0
    endcase
    sram = !s.unlock && s.sram_mask[0] && win;
    if (patch) begin
      r.rom_addr = s.addr;
    end else if (s.mapper == cart_pkg::MAP_MENU) begin
      r.rom_addr = sram ? s.addr : (({1'b0, s.addr[22:0]} & s.rom_mask) + `MENU_ROM_BASE);
    end else if (sram) begin
      r.rom_addr = `SAVERAM_BASE + (sav & s.sram_mask);
    end else begin
      r.rom_addr = rom & s.rom_mask;
    end
    r.is_rom = !s.romsel;
    r.is_saveram = sram;
    r.is_writable = sram || patch;
    r.rom_hit = r.is_rom || r.is_writable;
    r.msu = s.feat[`FEAT_MSU1] && !s.addr[22] && (off >= 16'h2000) && (off <= 16'h2007);
    r.dma = (s.feat[`FEAT_DMA1] || s.unlock) && !s.addr[22]
            && (off >= 16'h2020) && (off <= 16'h202f);
    dsp = 1'b0;
    a0 = 1'b1;
    if (s.mapper == cart_pkg::MAP_LOROM) begin
      // Big LoROM images push the DSP up to the low half of 60-6F
      dsp = s.rom_mask[20] ? ((bank[6:4] == 3'h6) && (off < 16'h8000))
                           : ((bank[6:4] == 3'h3) && (off >= 16'h8000));
      a0 = s.addr[14];
    end else if (s.mapper == cart_pkg::MAP_HIROM) begin
      dsp = (bank[6:4] == 3'h0) && (off >= 16'h6000) && (off < 16'h8000);
      a0 = s.addr[12];
    end
    r.dspx = s.feat[`FEAT_DSPX] && dsp;
    r.dspx_a0 = s.feat[`FEAT_DSPX] && a0;
    r.r213f = s.feat[`FEAT_213F] && (s.pa == 8'h3f);
    r.r2100 = (s.pa == 8'h00);
    r.snescmd = !s.addr[22] && (off >= 16'h2a00) && (off < 16'h3000);
    case (s.addr)
      24'h002BF2: r.cmd = cart_pkg::CMD_NMI;
      24'h002A6C: r.cmd = cart_pkg::CMD_RETURN;
      24'h002A1F: r.cmd = cart_pkg::CMD_BRANCH1;
      24'h002A59: r.cmd = cart_pkg::CMD_BRANCH2;
      24'h002A5E: r.cmd = cart_pkg::CMD_BRANCH3;
      default:    r.cmd = cart_pkg::CMD_NONE;
    endcase
    return r;
  endfunction

  //////////////////////////////
  // Checking

  task automatic check_addr(input string name, input logic [`CART_ADDR_W-1:0] exp_v,
                            input logic [`CART_ADDR_W-1:0] got);
    if (got !== exp_v) begin
      addr_errs++;
      $display("ERR %0t %s: expected %h, got %h", $time, name, exp_v, got);
    end
  endtask

  task automatic check_flag(input string name, input logic exp_v, input logic got);
    if (got !== exp_v) begin
      flag_errs++;
      $display("ERR %0t %s: expected %b, got %b", $time, name, exp_v, got);
    end
  endtask

  task automatic check_cmd(input string name, input cart_pkg::cmd_vec_t exp_v,
                           input cart_pkg::cmd_vec_t got);
    if (got !== exp_v) begin
      cmd_errs++;
      $display("ERR %0t %s: expected %0d, got %0d", $time, name, exp_v, got);
    end
  endtask

  // Outputs are stable mid-cycle
  always @(negedge CLK) begin
    exp_r = expect_resp(hist[2]);
    check_addr("rom_addr", exp_r.rom_addr, rom_addr);
    check_flag("is_rom", exp_r.is_rom, is_rom);
    check_flag("is_saveram", exp_r.is_saveram, is_saveram);
    check_flag("is_writable", exp_r.is_writable, is_writable);
    check_flag("rom_hit", exp_r.rom_hit, rom_hit);
    check_flag("msu_enable", exp_r.msu, msu_enable);
    check_flag("dma_enable", exp_r.dma, dma_enable);
    check_flag("dspx_enable", exp_r.dspx, dspx_enable);
    check_flag("dspx_a0", exp_r.dspx_a0, dspx_a0);
    check_flag("r213f_enable", exp_r.r213f, r213f_enable);
    check_flag("r2100_hit", exp_r.r2100, r2100_hit);
    check_flag("snescmd_enable", exp_r.snescmd, snescmd_enable);
    check_cmd("cmd_vec", exp_r.cmd, cmd_vec);
    if (hist[2].live) n_checked++;
  end

  initial begin : main_proc
    int   waited;
    logic timed_out;
    seed = 32'hd764a523;
    addr_errs = 0;
    flag_errs = 0;
    cmd_errs = 0;
    n_sent = 0;
    n_checked = 0;
    rst_left = 15;  // The time-zero value makes 16 reset edges
    hist[0] = idle_stim(1'b1);
    hist[1] = idle_stim(1'b1);
    hist[2] = idle_stim(1'b1);
    drive_inputs(idle_stim(1'b1));
    timed_out = 1'b0;
    waited = 0;
    while (n_checked == 0 && !timed_out) begin
      @(posedge CLK);
      waited++;
      if (waited > 64) timed_out = 1'b1;
    end
    waited = 0;
    while (n_checked < N_REQ && !timed_out) begin
      @(posedge CLK);
      waited++;
      if (waited > N_REQ + 16) timed_out = 1'b1;
    end
    if (timed_out) $display("Timeout: DUT results stopped arriving after %0d", n_checked);
    $display("Errors: rom_addr %0d, flags %0d, cmd_vec %0d", addr_errs, flag_errs, cmd_errs);
    if (!timed_out && (addr_errs + flag_errs + cmd_errs == 0)) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
